// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    parameter int xlen = 32;

    // major opcodes
    parameter logic [6:0] opc_op     = 7'b0110011;
    parameter logic [6:0] opc_op_imm = 7'b0010011;
    parameter logic [6:0] opc_system = 7'b1110011;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_nop,
        alu_halt
    } alu_op_e;

    // decoded instruction handed to execute
    typedef struct packed {
        alu_op_e         op;
        logic [4:0]      rd;
        logic            we;
        logic [xlen-1:0] op1;
        logic [xlen-1:0] op2;
    } uop_t;

    // apb address map
    parameter logic [11:0] imem_base    = 12'h000;
    parameter logic [11:0] reg_base     = 12'h400;
    parameter logic [11:0] ctrl_addr    = 12'h800;
    parameter logic [11:0] status_addr  = 12'h804;
    parameter logic [11:0] retired_addr = 12'h808;

endpackage

// ==== hdl/fetch_if.sv ====
interface fetch_if;

    logic                    valid;
    logic                    ready;
    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] inst;

    modport src (
        output valid,
        output pc,
        output inst,
        input  ready
    );

    modport dst (
        input  valid,
        input  pc,
        input  inst,
        output ready
    );

endinterface

// ==== hdl/inst_fetch.sv ====
module inst_fetch #(
    parameter int imem_depth = 256
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic                           halted,
    input  logic                           imem_we,
    input  logic [$clog2(imem_depth)-1:0]  imem_idx,
    input  logic [rv_pkg::xlen-1:0]        imem_wdata,
    output logic [rv_pkg::xlen-1:0]        imem_rdata,
    fetch_if.src                           out
);

    localparam int idx_w = $clog2(imem_depth);

    logic [rv_pkg::xlen-1:0] mem [imem_depth];
    logic [rv_pkg::xlen-1:0] pc;
    logic                    running;
    logic                    issue;

    // new item when the output slot is free or being taken
    assign issue = running && !halted && (!out.valid || out.ready);

    // apb side of the memory
    always_ff @(posedge clk) begin
        if (imem_we) begin
            mem[imem_idx] <= imem_wdata;
        end
    end

    assign imem_rdata = mem[imem_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running   <= 1'b0;
            pc        <= '0;
            out.valid <= 1'b0;
        end else if (start) begin
            running   <= 1'b1;
            pc        <= '0;
            out.valid <= 1'b0;
        end else begin
            if (halted) begin
                running <= 1'b0;
            end
            if (issue) begin
                out.valid <= 1'b1;
                pc        <= pc + 32'd4;
            end else if (out.ready) begin
                out.valid <= 1'b0;
            end
        end
    end

    // synchronous imem read straight into the output item
    always_ff @(posedge clk) begin
        if (issue) begin
            out.inst <= mem[pc[idx_w+1:2]];
            out.pc   <= pc;
        end
    end

endmodule

// ==== hdl/inst_queue.sv ====
module inst_queue #(
    parameter int queue_depth = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    fetch_if.dst in,
    fetch_if.src out
);

    localparam int ptr_w = $clog2(queue_depth);

    logic [rv_pkg::xlen-1:0] pc_mem   [queue_depth];
    logic [rv_pkg::xlen-1:0] inst_mem [queue_depth];
    logic [ptr_w-1:0]        wr_ptr;
    logic [ptr_w-1:0]        rd_ptr;
    logic [ptr_w:0]          count;
    logic                    push;
    logic                    pop;

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    assign in.ready  = (count != (ptr_w+1)'(queue_depth));
    assign out.valid = (count != '0);
    assign out.pc    = pc_mem[rd_ptr];
    assign out.inst  = inst_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]   <= in.pc;
            inst_mem[wr_ptr] <= in.inst;
        end
    end

    // flush on start so a rerun begins clean
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (start) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hdl/inst_decode.sv ====
module inst_decode (
    fetch_if.dst                    in,
    input  logic                    exec_ready,
    output logic [4:0]              rs1_addr,
    output logic [4:0]              rs2_addr,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    output rv_pkg::uop_t            uop,
    output logic                    fire
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [4:0]              rd;
    logic [rv_pkg::xlen-1:0] imm_i;
    logic                    r_legal;

    assign opcode = in.inst[6:0];
    assign funct3 = in.inst[14:12];
    assign funct7 = in.inst[31:25];
    assign rd     = in.inst[11:7];
    assign imm_i  = {{20{in.inst[31]}}, in.inst[31:20]};

    assign rs1_addr = in.inst[19:15];
    assign rs2_addr = in.inst[24:20];

    assign in.ready = exec_ready;
    assign fire     = in.valid && exec_ready;

    // funct7 0x20 only exists for sub and sra
    assign r_legal = (funct7 == 7'h00)
                  || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        uop.op  = rv_pkg::alu_nop;
        uop.rd  = 5'd0;
        uop.we  = 1'b0;
        uop.op1 = rs1_data;
        uop.op2 = rs2_data;
        case (opcode)
            rv_pkg::opc_op: begin
                if (r_legal) begin
                    uop.rd = rd;
                    uop.we = 1'b1;
                    case (funct3)
                        3'b000:  uop.op = funct7[5] ? rv_pkg::alu_sub : rv_pkg::alu_add;
                        3'b001:  uop.op = rv_pkg::alu_sll;
                        3'b010:  uop.op = rv_pkg::alu_slt;
                        3'b011:  uop.op = rv_pkg::alu_sltu;
                        3'b100:  uop.op = rv_pkg::alu_xor;
                        3'b101:  uop.op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                        3'b110:  uop.op = rv_pkg::alu_or;
                        default: uop.op = rv_pkg::alu_and;
                    endcase
                end
            end
            rv_pkg::opc_op_imm: begin
                uop.rd  = rd;
                uop.we  = 1'b1;
                uop.op2 = imm_i;
                case (funct3)
                    3'b000: uop.op = rv_pkg::alu_add;
                    3'b010: uop.op = rv_pkg::alu_slt;
                    3'b011: uop.op = rv_pkg::alu_sltu;
                    3'b100: uop.op = rv_pkg::alu_xor;
                    3'b110: uop.op = rv_pkg::alu_or;
                    3'b111: uop.op = rv_pkg::alu_and;
                    default: begin
                        // shifts take shamt only
                        uop.op2 = {27'd0, in.inst[24:20]};
                        if (funct3 == 3'b001 && funct7 == 7'h00) begin
                            uop.op = rv_pkg::alu_sll;
                        end else if (funct3 == 3'b101 && funct7 == 7'h00) begin
                            uop.op = rv_pkg::alu_srl;
                        end else if (funct3 == 3'b101 && funct7 == 7'h20) begin
                            uop.op = rv_pkg::alu_sra;
                        end else begin
                            uop.we = 1'b0;
                        end
                    end
                endcase
            end
            rv_pkg::opc_system: begin
                // ecall only, ebreak and csr ops fall through as nop
                if (in.inst[31:7] == 25'd0) begin
                    uop.op = rv_pkg::alu_halt;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/reg_file.sv ====
module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [4:0]              rs1_addr,
    input  logic [4:0]              rs2_addr,
    output logic [rv_pkg::xlen-1:0] rs1_data,
    output logic [rv_pkg::xlen-1:0] rs2_data,
    input  logic                    we,
    input  logic [4:0]              rd_addr,
    input  logic [rv_pkg::xlen-1:0] rd_data,
    input  logic [4:0]              dbg_addr,
    output logic [rv_pkg::xlen-1:0] dbg_data
);

    logic [rv_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];
    assign dbg_data = (dbg_addr == 5'd0) ? '0 : regs[dbg_addr];

endmodule

// ==== hdl/alu_exec.sv ====
module alu_exec (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    fire,
    input  rv_pkg::uop_t            uop,
    output logic                    ready,
    output logic                    we,
    output logic [4:0]              rd_addr,
    output logic [rv_pkg::xlen-1:0] rd_data,
    output logic                    halted,
    output logic [rv_pkg::xlen-1:0] retired
);

    logic [4:0] shamt;
    logic       live;

    // after halt items still drain but are dropped
    assign ready = 1'b1;
    assign live  = fire && !halted;
    assign shamt = uop.op2[4:0];

    always_comb begin
        case (uop.op)
            rv_pkg::alu_add:  rd_data = uop.op1 + uop.op2;
            rv_pkg::alu_sub:  rd_data = uop.op1 - uop.op2;
            rv_pkg::alu_sll:  rd_data = uop.op1 << shamt;
            rv_pkg::alu_slt:  rd_data = {31'd0, $signed(uop.op1) < $signed(uop.op2)};
            rv_pkg::alu_sltu: rd_data = {31'd0, uop.op1 < uop.op2};
            rv_pkg::alu_xor:  rd_data = uop.op1 ^ uop.op2;
            rv_pkg::alu_srl:  rd_data = uop.op1 >> shamt;
            rv_pkg::alu_sra:  rd_data = $unsigned($signed(uop.op1) >>> shamt);
            rv_pkg::alu_or:   rd_data = uop.op1 | uop.op2;
            rv_pkg::alu_and:  rd_data = uop.op1 & uop.op2;
            default:          rd_data = '0;
        endcase
    end

    assign we      = live && uop.we;
    assign rd_addr = uop.rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted  <= 1'b0;
            retired <= '0;
        end else if (start) begin
            halted  <= 1'b0;
            retired <= '0;
        end else if (live) begin
            // ecall counts as retired too
            retired <= retired + 1'b1;
            if (uop.op == rv_pkg::alu_halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/apb_ctrl.sv ====
module apb_ctrl #(
    parameter int imem_depth = 256
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [11:0]                   paddr,
    input  logic [rv_pkg::xlen-1:0]       pwdata,
    output logic [rv_pkg::xlen-1:0]       prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          imem_we,
    output logic [$clog2(imem_depth)-1:0] imem_idx,
    output logic [rv_pkg::xlen-1:0]       imem_wdata,
    input  logic [rv_pkg::xlen-1:0]       imem_rdata,
    output logic [4:0]                    reg_idx,
    input  logic [rv_pkg::xlen-1:0]       reg_data,
    output logic                          start,
    input  logic                          halted,
    input  logic [rv_pkg::xlen-1:0]       retired
);

    localparam int idx_w      = $clog2(imem_depth);
    localparam int imem_bytes = imem_depth * 4;

    logic [11:0] imem_off;
    logic [11:0] reg_off;
    logic        in_imem;
    logic        in_reg;
    logic        is_ctrl;
    logic        is_status;
    logic        is_retired;
    logic        mapped;
    logic        access;

    assign imem_off   = paddr - rv_pkg::imem_base;
    assign reg_off    = paddr - rv_pkg::reg_base;
    assign in_imem    = 32'(imem_off) < imem_bytes;
    assign in_reg     = reg_off < 12'd128;
    assign is_ctrl    = (paddr == rv_pkg::ctrl_addr);
    assign is_status  = (paddr == rv_pkg::status_addr);
    assign is_retired = (paddr == rv_pkg::retired_addr);
    // word aligned accesses only
    assign mapped = (paddr[1:0] == 2'b00)
                 && (in_imem || in_reg || is_ctrl || is_status || is_retired);

    assign access = psel && penable;

    assign pready  = 1'b1;
    assign pslverr = access && !mapped;

    assign imem_we    = access && pwrite && mapped && in_imem;
    assign imem_idx   = imem_off[idx_w+1:2];
    assign imem_wdata = pwdata;
    assign reg_idx    = reg_off[6:2];

    always_comb begin
        prdata = '0;
        if (mapped) begin
            if (in_imem) begin
                prdata = imem_rdata;
            end else if (in_reg) begin
                prdata = reg_data;
            end else if (is_status) begin
                prdata = {31'd0, halted};
            end else if (is_retired) begin
                prdata = retired;
            end
        end
    end

    // pulse lands the cycle after the ctrl write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= 1'b0;
        end else begin
            start <= access && pwrite && is_ctrl && pwdata[0];
        end
    end

endmodule

// ==== hdl/rv_core_top.sv ====
module rv_core_top #(
    parameter int imem_depth  = 256,
    parameter int queue_depth = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    localparam int idx_w = $clog2(imem_depth);

    logic                    imem_we;
    logic [idx_w-1:0]        imem_idx;
    logic [rv_pkg::xlen-1:0] imem_wdata;
    logic [rv_pkg::xlen-1:0] imem_rdata;
    logic [4:0]              reg_idx;
    logic [rv_pkg::xlen-1:0] reg_data;
    logic                    start;
    logic                    halted;
    logic [rv_pkg::xlen-1:0] retired;
    logic [4:0]              rs1_addr;
    logic [4:0]              rs2_addr;
    logic [rv_pkg::xlen-1:0] rs1_data;
    logic [rv_pkg::xlen-1:0] rs2_data;
    rv_pkg::uop_t            uop;
    logic                    fire;
    logic                    exec_ready;
    logic                    wb_we;
    logic [4:0]              wb_addr;
    logic [rv_pkg::xlen-1:0] wb_data;

    fetch_if fetch_q ();
    fetch_if q_dec ();

    inst_fetch #(
        .imem_depth (imem_depth)
    ) u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .halted     (halted),
        .imem_we    (imem_we),
        .imem_idx   (imem_idx),
        .imem_wdata (imem_wdata),
        .imem_rdata (imem_rdata),
        .out        (fetch_q.src)
    );

    inst_queue #(
        .queue_depth (queue_depth)
    ) u_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .in    (fetch_q.dst),
        .out   (q_dec.src)
    );

    inst_decode u_decode (
        .in         (q_dec.dst),
        .exec_ready (exec_ready),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .uop        (uop),
        .fire       (fire)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (wb_we),
        .rd_addr  (wb_addr),
        .rd_data  (wb_data),
        .dbg_addr (reg_idx),
        .dbg_data (reg_data)
    );

    alu_exec u_exec (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .fire    (fire),
        .uop     (uop),
        .ready   (exec_ready),
        .we      (wb_we),
        .rd_addr (wb_addr),
        .rd_data (wb_data),
        .halted  (halted),
        .retired (retired)
    );

    apb_ctrl #(
        .imem_depth (imem_depth)
    ) u_apb (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .imem_we    (imem_we),
        .imem_idx   (imem_idx),
        .imem_wdata (imem_wdata),
        .imem_rdata (imem_rdata),
        .reg_idx    (reg_idx),
        .reg_data   (reg_data),
        .start      (start),
        .halted     (halted),
        .retired    (retired)
    );

endmodule

// ==== dv/core_chk.sv ====
module core_chk (
    input logic clk,
    input logic rst_n,
    input logic psel,
    input logic penable,
    input logic pslverr,
    input logic halted,
    input logic start
);
    timeunit 1ns;
    timeprecision 100ps;

    // access phase only right after a setup phase
    setup_before_access: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> $past(psel && !penable)
    ) else $error("penable rose without a preceding setup cycle");

    // error only in the second cycle of a transfer
    err_in_access: assert property (
        @(posedge clk) disable iff (!rst_n)
        pslverr |-> (psel && penable && $past(psel && !penable))
    ) else $error("pslverr high outside an access cycle");

    // only a start pulse clears halted
    halt_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        (halted && !start) |=> halted
    ) else $error("halted dropped without a start pulse");

endmodule

bind rv_core_top core_chk u_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pslverr (pslverr),
    .halted  (halted),
    .start   (start)
);

// ==== dv/tb_top.sv ====
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    typedef struct {
        string           name;
        rv_pkg::alu_op_e op;
        bit              imm;
    } test_entry_t;

    test_entry_t test_q[$];
    logic [31:0] lcg_state;
    int          cycle_cnt = 0;

    rv_core_top #(
        .imem_depth  (256),
        .queue_depth (2)
    ) dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic stop_with_error(string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(string tname, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h actual %h", tname, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [11:0] draw12();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:20];
    endfunction

    function automatic logic [31:0] sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic bit is_shift(rv_pkg::alu_op_e op);
        return op == rv_pkg::alu_sll || op == rv_pkg::alu_srl || op == rv_pkg::alu_sra;
    endfunction

    // encodes x3 <= x1 op (x2 or imm)
    function automatic logic [31:0] encode_op(rv_pkg::alu_op_e op, bit imm, logic [11:0] b);
        logic [2:0] funct3;
        logic [6:0] funct7;
        funct7 = 7'h00;
        case (op)
            rv_pkg::alu_sub:  funct3 = 3'b000;
            rv_pkg::alu_sll:  funct3 = 3'b001;
            rv_pkg::alu_slt:  funct3 = 3'b010;
            rv_pkg::alu_sltu: funct3 = 3'b011;
            rv_pkg::alu_xor:  funct3 = 3'b100;
            rv_pkg::alu_srl:  funct3 = 3'b101;
            rv_pkg::alu_sra:  funct3 = 3'b101;
            rv_pkg::alu_or:   funct3 = 3'b110;
            rv_pkg::alu_and:  funct3 = 3'b111;
            default:          funct3 = 3'b000;
        endcase
        if (op == rv_pkg::alu_sub || op == rv_pkg::alu_sra) begin
            funct7 = 7'h20;
        end
        if (!imm) begin
            return {funct7, 5'd2, 5'd1, funct3, 5'd3, 7'b0110011};
        end else if (is_shift(op)) begin
            return {funct7, b[4:0], 5'd1, funct3, 5'd3, 7'b0010011};
        end
        return {b, 5'd1, funct3, 5'd3, 7'b0010011};
    endfunction

    function automatic logic [31:0] ref_result(rv_pkg::alu_op_e op, logic [31:0] x,
                                               logic [31:0] y);
        logic [4:0]  sh;
        logic [31:0] r;
        sh = y[4:0];
        case (op)
            rv_pkg::alu_add:  r = x + y;
            rv_pkg::alu_sub:  r = x - y;
            rv_pkg::alu_sll:  r = x << sh;
            // differing signs decide on the sign bit alone
            rv_pkg::alu_slt:  r = (x[31] != y[31]) ? {31'd0, x[31]} : {31'd0, x < y};
            rv_pkg::alu_sltu: r = {31'd0, x < y};
            rv_pkg::alu_xor:  r = x ^ y;
            rv_pkg::alu_srl:  r = x >> sh;
            rv_pkg::alu_sra:  r = (x >> sh) | (x[31] ? ~(32'hffffffff >> sh) : 32'd0);
            rv_pkg::alu_or:   r = x | y;
            rv_pkg::alu_and:  r = x & y;
            default:          r = 32'd0;
        endcase
        return r;
    endfunction

    task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int waits;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (pready !== 1'b1) begin
            if (waits > 16) begin
                stop_with_error("pready stayed low during an apb access");
            end
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check($sformatf("write %h pslverr", addr), 32'd0, {31'd0, err});
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        apb_access(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic read_mapped(input string tname, input logic [11:0] addr,
                               output logic [31:0] data);
        logic err;
        apb_read(addr, data, err);
        check({tname, " pslverr"}, 32'd0, {31'd0, err});
    endtask

    task automatic check_reg(string tname, int n, logic [31:0] expected);
        logic [31:0] val;
        read_mapped($sformatf("%s x%0d", tname, n), rv_pkg::reg_base + 12'(4 * n), val);
        check($sformatf("%s x%0d", tname, n), expected, val);
    endtask

    task automatic start_and_wait(string tname);
        int          t0;
        logic [31:0] status;
        bit          cleared;
        apb_write(rv_pkg::ctrl_addr, 32'd1);
        t0      = cycle_cnt;
        status  = 32'd0;
        cleared = 1'b0;
        while (status[0] !== 1'b1) begin
            if (cycle_cnt - t0 > 2000) begin
                stop_with_error($sformatf("%s: halted never came within 2000 cycles", tname));
            end
            read_mapped({tname, " status"}, rv_pkg::status_addr, status);
            if (status[0] === 1'b0) begin
                cleared = 1'b1;
            end
        end
        // start clears halted long before a short program reaches ecall
        if (!cleared) begin
            stop_with_error($sformatf("%s: halted did not clear after start", tname));
        end
    endtask

    task automatic add_entry(string name, rv_pkg::alu_op_e op, bit imm);
        test_entry_t e;
        e.name = name;
        e.op   = op;
        e.imm  = imm;
        test_q.push_back(e);
    endtask

    initial begin
        logic [11:0] a;
        logic [11:0] b;
        logic [31:0] prog [5];
        logic [31:0] op2;
        logic [31:0] rdata;
        logic        err;
        string       tname;

        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = 12'd0;
        pwdata    = 32'd0;
        rst_n     = 1'b0;
        lcg_state = 32'hfb314f0f;

        add_entry("add", rv_pkg::alu_add, 1'b0);
        add_entry("sub", rv_pkg::alu_sub, 1'b0);
        add_entry("sll", rv_pkg::alu_sll, 1'b0);
        add_entry("slt", rv_pkg::alu_slt, 1'b0);
        add_entry("sltu", rv_pkg::alu_sltu, 1'b0);
        add_entry("xor", rv_pkg::alu_xor, 1'b0);
        add_entry("srl", rv_pkg::alu_srl, 1'b0);
        add_entry("sra", rv_pkg::alu_sra, 1'b0);
        add_entry("or", rv_pkg::alu_or, 1'b0);
        add_entry("and", rv_pkg::alu_and, 1'b0);
        add_entry("addi", rv_pkg::alu_add, 1'b1);
        add_entry("slti", rv_pkg::alu_slt, 1'b1);
        add_entry("sltiu", rv_pkg::alu_sltu, 1'b1);
        add_entry("xori", rv_pkg::alu_xor, 1'b1);
        add_entry("ori", rv_pkg::alu_or, 1'b1);
        add_entry("andi", rv_pkg::alu_and, 1'b1);
        add_entry("slli", rv_pkg::alu_sll, 1'b1);
        add_entry("srli", rv_pkg::alu_srl, 1'b1);
        add_entry("srai", rv_pkg::alu_sra, 1'b1);

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        foreach (test_q[i]) begin
            a = draw12();
            b = draw12();
            prog[0] = {a, 5'd0, 3'b000, 5'd1, 7'b0010011};
            prog[1] = {b, 5'd0, 3'b000, 5'd2, 7'b0010011};
            prog[2] = encode_op(test_q[i].op, test_q[i].imm, b);
            prog[3] = 32'h00000073;
            prog[4] = {12'd1, 5'd0, 3'b000, 5'd4, 7'b0010011};
            for (int k = 0; k < 5; k++) begin
                apb_write(12'(4 * k), prog[k]);
            end
            op2 = sext12(b);
            if (test_q[i].imm && is_shift(test_q[i].op)) begin
                op2 = {27'd0, b[4:0]};
            end
            // second pass reruns the same program
            for (int run = 0; run < 2; run++) begin
                tname = $sformatf("%s run%0d", test_q[i].name, run);
                start_and_wait(tname);
                check_reg(tname, 1, sext12(a));
                check_reg(tname, 2, sext12(b));
                check_reg(tname, 3, ref_result(test_q[i].op, sext12(a), op2));
                check_reg(tname, 4, 32'd0);
                read_mapped({tname, " retired"}, rv_pkg::retired_addr, rdata);
                check({tname, " retired"}, 32'd4, rdata);
            end
        end

        // x0 must stay zero
        apb_write(12'h000, {12'd5, 5'd0, 3'b000, 5'd0, 7'b0010011});
        apb_write(12'h004, 32'h00000073);
        start_and_wait("x0 write");
        check_reg("x0 write", 0, 32'd0);
        read_mapped("x0 write retired", rv_pkg::retired_addr, rdata);
        check("x0 write retired", 32'd2, rdata);

        op2 = {draw12(), draw12(), 8'h5a};
        apb_write(12'h3f0, op2);
        read_mapped("imem readback", 12'h3f0, rdata);
        check("imem readback", op2, rdata);

        apb_read(12'hc00, rdata, err);
        check("unmapped pslverr", 32'd1, {31'd0, err});

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== src.f ====
hdl/rv_pkg.sv
hdl/fetch_if.sv
hdl/inst_fetch.sv
hdl/inst_queue.sv
hdl/inst_decode.sv
hdl/reg_file.sv
hdl/alu_exec.sv
hdl/apb_ctrl.sv
hdl/rv_core_top.sv
dv/core_chk.sv
dv/tb_top.sv

// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
TOP       = tb_top
FILE_LIST = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
